// ==== verif/traffic_testdata.txt ====
// kind a b c d n m e0 e1, all hex, one test per line
// kinds 1-3: a len b interleave c port d random n/m aw/ar accepts e0/e1 awaddr/araddr
// kind 4: a len n beats e0 last beats
// kind 5: a/b write/read beats c/d error beat (0 none) n resp_error e0/e1 ok counts

// sequential addressing, one per length and interleave
1 0 0 13 0 3 5 130000060 1300000a0
1 3 1 1a 0 6 2 1a0000300 1a0000100
1 f 2 1f 0 9 4 1c0001200 1c0000800
1 7 3 0c 0 7 c 080000700 080000c00
1 1 4 15 0 a 1 100000280 100000040
1 0 5 1f 0 8 0 000000100 000000000

// interleave sweep, stripe 3, BL4
2 3 0 1f 0 3 3 1f0000180 1f0000180
2 3 1 1f 0 3 3 1e0000180 1e0000180
2 3 2 1f 0 3 3 1c0000180 1c0000180
2 3 3 1f 0 3 3 180000180 180000180
2 3 4 1f 0 3 3 100000180 100000180
2 3 5 1f 0 3 3 000000180 000000180

// random stride table, rank 0
3 0 5 00 1 5 2 000018b40 00000a560
3 7 2 09 1 d 0 0801f8200 080006100
3 f 0 04 1 14 7 040608a00 040224800

// write bursts BL1 BL4 BL16
4 0 0 00 0 a 0 a 0
4 3 0 00 0 18 0 6 0
4 f 0 00 0 30 0 3 0

// responses
5 6 4 0 0 0 0 6 4
5 8 5 3 0 1 0 7 5
5 3 9 0 9 1 0 3 8
5 5 5 1 2 1 0 4 4

// ==== all.f ====
design/traffic_pkg.sv
design/stride_table.sv
design/stripe_counter.sv
design/addr_composer.sv
design/write_burst.sv
design/resp_monitor.sv
design/traffic_master_top.sv
verif/tb_clock.sv
verif/traffic_master_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module traffic_master_tb -f all.f \
    && ./obj_dir/Vtraffic_master_tb | tee sim.log \
    || { echo "verilator build or simulation run failed"; exit 1; }

grep -qx "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verif/traffic_master_tb.sv ====
`timescale 1ns/100ps

module traffic_master_tb
    import traffic_pkg::*;
();

    // words per vector line
    localparam int FIELDS      = 9;
    localparam int MAX_TESTS   = 64;
    // watchdog budget per test
    localparam int TEST_CYCLES = 400;
    // address path settles in 4 cycles plus margin
    localparam int SETTLE      = 6;
    // idle cycles after each address accept
    localparam int ACCEPT_GAP  = 5;

    logic               aclk;
    logic               aresetn;
    logic               restart;
    logic               is_write;
    logic               is_read;
    burst_len_e         burst_len;
    interleave_e        interleave;
    logic [PORT_W-1:0]  port_select;
    logic               random_mode;
    logic               awready;
    logic               arready;
    logic               wready;
    logic [DATA_W-1:0]  wdata_in;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               rvalid;
    logic [1:0]         rresp;
    logic [ADDR_W-1:0]  awaddr;
    logic [ADDR_W-1:0]  araddr;
    logic [LEN_W-1:0]   awlen;
    logic [LEN_W-1:0]   arlen;
    logic               awvalid;
    logic               arvalid;
    logic [DATA_W-1:0]  wdata;
    logic               wlast;
    logic [COUNT_W-1:0] write_ok_count;
    logic [COUNT_W-1:0] read_ok_count;
    logic               resp_error;

    // unused vector words stay all ones
    logic [35:0] vec [MAX_TESTS*FIELDS];
    int          num_tests;
    int          test_errors;
    int          passed;
    int          failed;
    logic        loaded;
    logic [31:0] rng;

    tb_clock clkgen (
        .restart (restart),
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    traffic_master_top UUT (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .is_write       (is_write),
        .is_read        (is_read),
        .burst_len      (burst_len),
        .interleave     (interleave),
        .port_select    (port_select),
        .random_mode    (random_mode),
        .awready        (awready),
        .arready        (arready),
        .awaddr         (awaddr),
        .araddr         (araddr),
        .awlen          (awlen),
        .arlen          (arlen),
        .awvalid        (awvalid),
        .arvalid        (arvalid),
        .wready         (wready),
        .wdata_in       (wdata_in),
        .wdata          (wdata),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bresp          (bresp),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .write_ok_count (write_ok_count),
        .read_ok_count  (read_ok_count),
        .resp_error     (resp_error)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [35:0] field(input int t, input int k);
        return vec[t * FIELDS + k];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ready about three cycles in four
    task automatic draw_ready(output logic rdy);
        rng = lcg_next(rng);
        rdy = (rng[17:16] != 2'b00);
    endtask

    // stripe after n accepts by the rank 0 walk and table rule
    function automatic logic [STRIPE_W-1:0] table_stripe(input int n);
        int ptr;
        int entry;
        ptr = 0;
        for (int k = 0; k < n; k++) begin
            if (ptr < RAND_WRAP) begin
                ptr = ptr + 1;
            end else begin
                ptr = ptr - RAND_WRAP;
            end
        end
        entry = ((ptr % TABLE_DEPTH) * STRIDE_MULT + STRIDE_ADD) % (1 << TABLE_VAL_W);
        return STRIPE_W'(entry);
    endfunction

    // port bits on top and stripe above a zero byte offset
    function automatic logic [ADDR_W-1:0] compose_addr(input logic [STRIPE_W-1:0] stripe,
            input burst_len_e bl, input interleave_e il, input logic [PORT_W-1:0] port);
        int off_bits;
        int port_bits;
        int stripe_bits;
        logic [ADDR_W-1:0] a;
        off_bits    = BEAT_BYTES_LOG + $clog2(int'(bl) + 1);
        port_bits   = PORT_W - int'(il);
        stripe_bits = ADDR_W - port_bits - off_bits;
        a = '0;
        for (int k = 0; k < stripe_bits; k++) begin
            a[off_bits + k] = stripe[k];
        end
        for (int k = 0; k < port_bits; k++) begin
            a[ADDR_W - port_bits + k] = port[int'(il) + k];
        end
        return a;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic addr_check(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %09h expected %09h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic len_check(input logic [LEN_W-1:0] got, input burst_len_e exp,
            input string what);
        if (got !== LEN_W'(exp)) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic data_check(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %064h expected %064h",
                $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic count_check(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic flag_check(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    //////////////////////////////
    // test procedures
    //////////////////////////////

    // mode inputs then a fresh reset
    task automatic apply_config(input int t, input int kind);
        logic [35:0] f_len;
        logic [35:0] f_il;
        logic [35:0] f_port;
        logic [35:0] f_rnd;
        f_len  = field(t, 1);
        f_il   = field(t, 2);
        f_port = field(t, 3);
        f_rnd  = field(t, 4);
        @(negedge aclk);
        if (kind <= 4) begin
            burst_len   = burst_len_e'(f_len[LEN_W-1:0]);
            interleave  = interleave_e'(f_il[2:0]);
            port_select = f_port[PORT_W-1:0];
            random_mode = f_rnd[0];
        end else begin
            // response tests use the columns as counts
            burst_len   = BL1;
            interleave  = IL_NONE;
            port_select = '0;
            random_mode = 1'b0;
        end
        restart = 1'b1;
        @(negedge aclk);
        restart = 1'b0;
        wait (aresetn);
        @(negedge aclk);
    endtask

    // n accepts on one channel with lcg gapped ready
    task automatic issue_accepts(input int n, input logic wr);
        int   done;
        logic rdy;
        done = 0;
        while (done < n) begin
            @(negedge aclk);
            draw_ready(rdy);
            if (wr) begin
                is_write = 1'b1;
                awready  = rdy;
            end else begin
                is_read = 1'b1;
                arready = rdy;
            end
            // valids follow the command levels
            @(posedge aclk);
            flag_check(awvalid, wr, "awvalid");
            flag_check(arvalid, !wr, "arvalid");
            // taken at this rising edge
            if (rdy) begin
                done++;
                @(negedge aclk);
                is_write = 1'b0;
                is_read  = 1'b0;
                awready  = 1'b0;
                arready  = 1'b0;
                repeat (ACCEPT_GAP - 1) @(negedge aclk);
            end
        end
    endtask

    task automatic address_test(input int t);
        int                n_w;
        int                n_r;
        logic [ADDR_W-1:0] exp_aw;
        logic [ADDR_W-1:0] exp_ar;
        n_w    = int'(field(t, 5));
        n_r    = int'(field(t, 6));
        exp_aw = ADDR_W'(field(t, 7));
        exp_ar = ADDR_W'(field(t, 8));
        // different counts per channel keep them apart
        issue_accepts(n_w, 1'b1);
        issue_accepts(n_r, 1'b0);
        repeat (SETTLE) @(negedge aclk);
        addr_check(awaddr, exp_aw, "awaddr");
        addr_check(araddr, exp_ar, "araddr");
        len_check(awlen, burst_len, "awlen");
        len_check(arlen, burst_len, "arlen");
        if (random_mode) begin
            addr_check(awaddr, compose_addr(table_stripe(n_w), burst_len, interleave,
                port_select), "awaddr from table rule");
            addr_check(araddr, compose_addr(table_stripe(n_r), burst_len, interleave,
                port_select), "araddr from table rule");
        end
    endtask

    task automatic burst_test(input int t);
        int                n_beats;
        int                beats;
        int                lasts;
        logic              rdy;
        logic              exp_last;
        logic [DATA_W-1:0] sent;
        n_beats = int'(field(t, 5));
        beats   = 0;
        lasts   = 0;
        sent    = wdata_in;
        while (beats < n_beats) begin
            @(negedge aclk);
            // data driven on the previous falling edge passes straight through
            data_check(wdata, sent, "wdata");
            draw_ready(rdy);
            wready   = rdy;
            sent     = {(DATA_W / 32){rng}};
            wdata_in = sent;
            // wlast here belongs to the beat taken at the next rising edge
            if (rdy) begin
                beats++;
                exp_last = ((beats % (int'(burst_len) + 1)) == 0);
                flag_check(wlast, exp_last, $sformatf("wlast on beat %0d", beats));
                if (wlast) begin
                    lasts++;
                end
            end
        end
        @(negedge aclk);
        data_check(wdata, sent, "wdata");
        wready = 1'b0;
        count_check(COUNT_W'(lasts), COUNT_W'(field(t, 7)), "last beats");
    endtask

    task automatic response_test(input int t);
        int          n_b;
        int          n_r;
        int          err_b;
        int          err_r;
        int          sent_b;
        int          sent_r;
        logic [35:0] f_err;
        logic        rdy;
        n_b    = int'(field(t, 1));
        n_r    = int'(field(t, 2));
        err_b  = int'(field(t, 3));
        err_r  = int'(field(t, 4));
        f_err  = field(t, 5);
        sent_b = 0;
        sent_r = 0;
        while (sent_b < n_b || sent_r < n_r) begin
            @(negedge aclk);
            bvalid = 1'b0;
            rvalid = 1'b0;
            bresp  = RESP_OKAY;
            rresp  = RESP_OKAY;
            draw_ready(rdy);
            if (rdy && sent_b < n_b) begin
                sent_b++;
                bvalid = 1'b1;
                // slverr on the chosen write beat
                bresp  = (sent_b == err_b) ? 2'b10 : RESP_OKAY;
            end
            draw_ready(rdy);
            if (rdy && sent_r < n_r) begin
                sent_r++;
                rvalid = 1'b1;
                // decerr on the chosen read beat
                rresp  = (sent_r == err_r) ? 2'b11 : RESP_OKAY;
            end
        end
        @(negedge aclk);
        bvalid = 1'b0;
        rvalid = 1'b0;
        @(negedge aclk);
        count_check(write_ok_count, COUNT_W'(field(t, 7)), "write_ok_count");
        count_check(read_ok_count, COUNT_W'(field(t, 8)), "read_ok_count");
        flag_check(resp_error, f_err[0], "resp_error");
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            1:       return "sequential address";
            2:       return "interleave";
            3:       return "random address";
            4:       return "write burst";
            5:       return "responses";
            default: return "unknown";
        endcase
    endfunction

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin : main
        int kind;
        restart     = 1'b0;
        is_write    = 1'b0;
        is_read     = 1'b0;
        burst_len   = BL1;
        interleave  = IL_NONE;
        port_select = '0;
        random_mode = 1'b0;
        awready     = 1'b0;
        arready     = 1'b0;
        wready      = 1'b0;
        wdata_in    = '0;
        bvalid      = 1'b0;
        bresp       = RESP_OKAY;
        rvalid      = 1'b0;
        rresp       = RESP_OKAY;
        rng         = 32'd7085;
        passed      = 0;
        failed      = 0;
        loaded      = 1'b0;
        for (int i = 0; i < MAX_TESTS * FIELDS; i++) begin
            vec[i] = '1;
        end
        $readmemh("verif/traffic_testdata.txt", vec);
        num_tests = 0;
        while (num_tests < MAX_TESTS && vec[num_tests * FIELDS] != '1) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test vectors could be read from verif/traffic_testdata.txt");
            failed++;
        end
        loaded = (num_tests > 0);
        wait (aresetn);
        for (int t = 0; t < num_tests; t++) begin
            test_errors = 0;
            kind = int'(field(t, 0));
            apply_config(t, kind);
            case (kind)
                1, 2, 3: address_test(t);
                4:       burst_test(t);
                5:       response_test(t);
                default: begin
                    $display("test %0d has an unknown kind %0d in the data file", t, kind);
                    test_errors++;
                end
            endcase
            if (test_errors == 0) begin
                passed++;
                $display("test %0d %s ok", t, kind_name(kind));
            end else begin
                failed++;
                $display("test %0d %s failed, %0d errors", t, kind_name(kind), test_errors);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", num_tests, passed, failed);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // bounded by the number of tests read
    initial begin : watchdog
        wait (loaded === 1'b1);
        repeat (num_tests * TEST_CYCLES) @(posedge aclk);
        $display("watchdog expired, tests did not finish within %0d cycles",
            num_tests * TEST_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    input  logic restart,
    output logic aclk,
    output logic aresetn
);

    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        aclk = 1'b0;
        forever begin
            #HALF_PERIOD aclk = ~aclk;
        end
    end

    // low at start, then again on every restart pulse
    initial begin
        forever begin
            aresetn = 1'b0;
            repeat (RESET_CYCLES) @(posedge aclk);
            // released on the falling edge like the other inputs
            @(negedge aclk);
            aresetn = 1'b1;
            @(posedge restart);
        end
    end

endmodule

// ==== design/traffic_master_top.sv ====
`timescale 1ns/100ps

module traffic_master_top
    import traffic_pkg::*;
#(
    parameter int gen_rank = 0
) (
    input  logic                aclk,
    input  logic                aresetn,
    // command side
    input  logic                is_write,
    input  logic                is_read,
    input  burst_len_e          burst_len,
    input  interleave_e         interleave,
    input  logic [PORT_W-1:0]   port_select,
    input  logic                random_mode,
    // address channels
    input  logic                awready,
    input  logic                arready,
    output logic [ADDR_W-1:0]   awaddr,
    output logic [ADDR_W-1:0]   araddr,
    output logic [LEN_W-1:0]    awlen,
    output logic [LEN_W-1:0]    arlen,
    output logic                awvalid,
    output logic                arvalid,
    // write data channel
    input  logic                wready,
    input  logic [DATA_W-1:0]   wdata_in,
    output logic [DATA_W-1:0]   wdata,
    output logic                wlast,
    // response channels
    input  logic                bvalid,
    input  logic [1:0]          bresp,
    input  logic                rvalid,
    input  logic [1:0]          rresp,
    output logic [COUNT_W-1:0]  write_ok_count,
    output logic [COUNT_W-1:0]  read_ok_count,
    output logic                resp_error
);

    logic                   aw_accept;
    logic                   ar_accept;
    logic [TABLE_IDX_W-1:0] w_idx;
    logic [TABLE_IDX_W-1:0] r_idx;
    logic [TABLE_VAL_W-1:0] w_tdata;
    logic [TABLE_VAL_W-1:0] r_tdata;
    logic [STRIPE_W-1:0]    w_stripe_val;
    logic [STRIPE_W-1:0]    r_stripe_val;

    //////////////////////////////
    // channel valids and accepts
    //////////////////////////////

    // valids follow the command levels, no handshake hold
    assign awvalid = is_write;
    assign arvalid = is_read;
    assign awlen   = burst_len;
    assign arlen   = burst_len;
    assign wdata   = wdata_in;

    // address taken when valid and ready meet
    assign aw_accept = awvalid & awready;
    assign ar_accept = arvalid & arready;

    //////////////////////////////
    // address generation
    //////////////////////////////

    // one table shared by both channels, port a write, port b read
    stride_table u_table (
        .aclk   (aclk),
        .idx_a  (w_idx),
        .idx_b  (r_idx),
        .data_a (w_tdata),
        .data_b (r_tdata)
    );

    stripe_counter #(.gen_rank(gen_rank)) w_stripe (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .accept      (aw_accept),
        .random_mode (random_mode),
        .table_data  (w_tdata),
        .table_idx   (w_idx),
        .stripe      (w_stripe_val)
    );

    stripe_counter #(.gen_rank(gen_rank)) r_stripe (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .accept      (ar_accept),
        .random_mode (random_mode),
        .table_data  (r_tdata),
        .table_idx   (r_idx),
        .stripe      (r_stripe_val)
    );

    // each channel composes its own address
    addr_composer w_addr (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .stripe      (w_stripe_val),
        .burst_len   (burst_len),
        .interleave  (interleave),
        .port_select (port_select),
        .addr        (awaddr)
    );

    addr_composer r_addr (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .stripe      (r_stripe_val),
        .burst_len   (burst_len),
        .interleave  (interleave),
        .port_select (port_select),
        .addr        (araddr)
    );

    //////////////////////////////
    // data and responses
    //////////////////////////////

    // wvalid is high outside, so wready alone takes a beat
    write_burst u_wburst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .wready    (wready),
        .burst_len (burst_len),
        .wlast     (wlast)
    );

    resp_monitor u_resp (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .bvalid         (bvalid),
        .bresp          (bresp),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .write_ok_count (write_ok_count),
        .read_ok_count  (read_ok_count),
        .resp_error     (resp_error)
    );

endmodule

// ==== design/resp_monitor.sv ====
`timescale 1ns/100ps

module resp_monitor
    import traffic_pkg::*;
(
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               bvalid,
    input  logic [1:0]         bresp,
    input  logic               rvalid,
    input  logic [1:0]         rresp,
    output logic [COUNT_W-1:0] write_ok_count,
    output logic [COUNT_W-1:0] read_ok_count,
    output logic               resp_error
);

    logic b_okay;
    logic r_okay;
    logic any_err;

    // bready and rready high outside, valid alone is a beat
    assign b_okay  = bvalid && (bresp == RESP_OKAY);
    assign r_okay  = rvalid && (rresp == RESP_OKAY);
    assign any_err = (bvalid && (bresp != RESP_OKAY))
                  || (rvalid && (rresp != RESP_OKAY));

    //////////////////////////////
    // counters and error flag
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            write_ok_count <= '0;
            read_ok_count  <= '0;
            resp_error     <= 1'b0;
        end else begin
            if (b_okay) begin
                write_ok_count <= write_ok_count + 1'b1;
            end
            if (r_okay) begin
                read_ok_count <= read_ok_count + 1'b1;
            end
            // sticky until reset
            if (any_err) begin
                resp_error <= 1'b1;
            end
        end
    end

endmodule

// ==== design/write_burst.sv ====
`timescale 1ns/100ps

module write_burst
    import traffic_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       wready,
    input  burst_len_e burst_len,
    output logic       wlast
);

    // beats taken so far in the current burst
    logic [LEN_W-1:0] beat_cnt;

    //////////////////////////////
    // beat counter
    //////////////////////////////

    // last beat once count reaches len field
    assign wlast = (beat_cnt == LEN_W'(burst_len));

    // wvalid held high outside, wready alone moves a beat
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (wready) begin
            // next burst starts after the last beat
            if (wlast) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/addr_composer.sv ====
`timescale 1ns/100ps

module addr_composer
    import traffic_pkg::*;
(
    input  logic                aclk,
    input  logic                aresetn,
    input  logic [STRIPE_W-1:0] stripe,
    input  burst_len_e          burst_len,
    input  interleave_e         interleave,
    input  logic [PORT_W-1:0]   port_select,
    output logic [ADDR_W-1:0]   addr
);

    logic [2:0]        len_log;
    logic [2:0]        drop;
    logic [2:0]        port_w;
    logic [5:0]        off_w;
    logic [5:0]        stripe_w;
    logic [ADDR_W-1:0] stripe_mask;
    logic [ADDR_W-1:0] port_field;
    logic [ADDR_W-1:0] next_addr;

    //////////////////////////////
    // field widths
    //////////////////////////////

    // layout, msb first: port field | stripe | zero offset
    always_comb begin
        // log2 of beats per burst
        case (burst_len)
            BL1:     len_log = 3'd0;
            BL2:     len_log = 3'd1;
            BL4:     len_log = 3'd2;
            BL8:     len_log = 3'd3;
            BL16:    len_log = 3'd4;
            default: len_log = 3'd0;
        endcase
        // unnamed codes treated as no port bits
        if (interleave > IL_NONE) begin
            drop = 3'(IL_NONE);
        end else begin
            drop = 3'(interleave);
        end
        port_w   = 3'(PORT_W) - drop;
        off_w    = 6'(BEAT_BYTES_LOG) + 6'(len_log);
        // stripe takes what is left, 19 to 28 bits
        stripe_w = 6'(ADDR_W) - 6'(port_w) - off_w;
    end

    //////////////////////////////
    // packing
    //////////////////////////////

    always_comb begin
        stripe_mask = (ADDR_W'(1) << stripe_w) - ADDR_W'(1);
        // low port bits dropped, rest sits at the top
        port_field  = ADDR_W'(port_select >> drop);
        next_addr   = (port_field << (off_w + stripe_w))
                    | ((ADDR_W'(stripe) & stripe_mask) << off_w);
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            addr <= '0;
        end else begin
            addr <= next_addr;
        end
    end

endmodule

// ==== design/stripe_counter.sv ====
`timescale 1ns/100ps

module stripe_counter
    import traffic_pkg::*;
#(
    parameter int gen_rank = 0
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   accept,
    input  logic                   random_mode,
    input  logic [TABLE_VAL_W-1:0] table_data,
    output logic [TABLE_IDX_W-1:0] table_idx,
    output logic [STRIPE_W-1:0]    stripe
);

    // step in random mode, rank spreads the generators apart
    localparam logic [STRIPE_W-1:0] RAND_STEP = STRIPE_W'(gen_rank + 1);
    localparam logic [STRIPE_W-1:0] WRAP_VAL  = STRIPE_W'(RAND_WRAP);

    logic [STRIPE_W-1:0] ptr;

    //////////////////////////////
    // pointer
    //////////////////////////////

    // moves one cycle after each accept
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ptr <= '0;
        end else if (accept) begin
            if (random_mode) begin
                // walk then fold back below the wrap point
                if (ptr < WRAP_VAL) begin
                    ptr <= ptr + RAND_STEP;
                end else begin
                    ptr <= ptr - WRAP_VAL;
                end
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // table lookup on the pointer low bits
    assign table_idx = ptr[TABLE_IDX_W-1:0];

    //////////////////////////////
    // stripe select
    //////////////////////////////

    // sequential lands one cycle after ptr,
    // random one more for the table read
    always_ff @(posedge aclk) begin
        if (random_mode) begin
            stripe <= STRIPE_W'(table_data);
        end else begin
            stripe <= ptr;
        end
    end

endmodule

// ==== design/stride_table.sv ====
`timescale 1ns/100ps

module stride_table
    import traffic_pkg::*;
(
    input  logic                   aclk,
    input  logic [TABLE_IDX_W-1:0] idx_a,
    input  logic [TABLE_IDX_W-1:0] idx_b,
    output logic [TABLE_VAL_W-1:0] data_a,
    output logic [TABLE_VAL_W-1:0] data_b
);

    logic [TABLE_VAL_W-1:0] rom [TABLE_DEPTH];

    //////////////////////////////
    // contents
    //////////////////////////////

    // scrambled stripe numbers, linear rule mod 2**20
    initial begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            rom[i] = TABLE_VAL_W'(i * STRIDE_MULT + STRIDE_ADD);
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // both ports registered, one cycle latency
    always_ff @(posedge aclk) begin
        data_a <= rom[idx_a];
        data_b <= rom[idx_b];
    end

endmodule

// ==== design/traffic_pkg.sv ====
package traffic_pkg;

    //////////////////////////////
    // address geometry
    //////////////////////////////

    // full burst address, 8 GB space
    localparam int ADDR_W         = 33;
    // port-select input width
    localparam int PORT_W         = 5;
    // widest stripe field, single beat with no port bits
    localparam int STRIPE_W       = 28;
    // 32-byte beats
    localparam int BEAT_BYTES_LOG = 5;
    localparam int DATA_W         = 256;
    // axi3 awlen / arlen field
    localparam int LEN_W          = 4;

    //////////////////////////////
    // random stride table
    //////////////////////////////

    localparam int TABLE_DEPTH    = 1024;
    localparam int TABLE_IDX_W    = 10;
    localparam int TABLE_VAL_W    = 20;
    // entry i = (i * mult + add) mod 2**TABLE_VAL_W
    localparam int STRIDE_MULT    = 613;
    localparam int STRIDE_ADD     = 97;
    // random pointer folds back once it passes this
    localparam int RAND_WRAP      = 1000;

    //////////////////////////////
    // responses
    //////////////////////////////

    localparam int COUNT_W        = 16;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // burst length minus one, as carried on awlen / arlen
    typedef enum logic [LEN_W-1:0] {
        BL1  = 4'd0,
        BL2  = 4'd1,
        BL4  = 4'd3,
        BL8  = 4'd7,
        BL16 = 4'd15
    } burst_len_e;

    // number of low port-select bits dropped from the address
    typedef enum logic [2:0] {
        IL_PORT5 = 3'd0,
        IL_PORT4 = 3'd1,
        IL_PORT3 = 3'd2,
        IL_PORT2 = 3'd3,
        IL_PORT1 = 3'd4,
        IL_NONE  = 3'd5
    } interleave_e;

endpackage
